// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= gat_tb
RTL_TOP   ?= gat_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing --assert
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && ! grep -q "%Error" $(LOG) || \
		{ echo "Simulation FAILED, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: attention/attention_coef.sv
`default_nettype none

`include "gat_params.svh"

module attention_coef (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                row_done,
  input  gat_pkg::node_info_t                 row_info,
  input  gat_pkg::row_addr_t                  row_addr,
  input  gat_pkg::wh_vec_t                    wh,
  input  gat_pkg::data_t [`GAT_A_DEPTH-1:0]   a_vec,
  output logic                                wh_wr_en,
  output gat_pkg::row_addr_t                  wh_wr_addr,
  output gat_pkg::wh_record_t                 wh_wr_data
);
  import gat_pkg::*;

  data_t coef_src;
  data_t coef_dst;

  // Low half of a for the source, high half for the destination
  always_comb begin
    coef_src = '0;
    coef_dst = '0;
    for (int j = 0; j < `GAT_W_COLS; j++) begin
      coef_src = coef_src + data_t'(a_vec[j] * wh[j]);
      coef_dst = coef_dst + data_t'(a_vec[`GAT_W_COLS + j] * wh[j]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wh_wr_en <= 1'b0;
    end else begin
      wh_wr_en <= row_done;
    end
  end

  // Record payload
  always_ff @(posedge clk) begin
    if (row_done) begin
      wh_wr_addr           <= row_addr;
      wh_wr_data.wh        <= wh;
      wh_wr_data.coef_src  <= coef_src;
      wh_wr_data.coef_dst  <= coef_dst;
      wh_wr_data.num_nodes <= row_info.num_nodes;
      wh_wr_data.flag      <= row_info.flag;
    end
  end

endmodule

`default_nettype wire

// File: common/gat_params.svh
`ifndef GAT_PARAMS_SVH
`define GAT_PARAMS_SVH

// Width of every value in H, W, a and WH
`define GAT_DATA_WIDTH 8

//////////////////////////////////////////////////////////////////////
// Matrix shapes
//////////////////////////////////////////////////////////////////////

`define GAT_H_ROWS 10
`define GAT_H_COLS 4

// Also the number of MAC lanes
`define GAT_W_COLS 4

// W flattened row major, row times GAT_W_COLS plus column
`define GAT_W_DEPTH (`GAT_H_COLS * `GAT_W_COLS)

//////////////////////////////////////////////////////////////////////
// Memory depths
//////////////////////////////////////////////////////////////////////

`define GAT_NNZ_DEPTH 32
`define GAT_NODE_INFO_DEPTH 16
`define GAT_WH_DEPTH 16
`define GAT_A_DEPTH 8

// Largest neighbourhood
`define GAT_NUM_NODES 5

`endif

// File: common/gat_pkg.sv
`default_nettype none

`include "gat_params.svh"

package gat_pkg;

  typedef logic [`GAT_DATA_WIDTH-1:0]                data_t;
  typedef logic [$clog2(`GAT_H_COLS)-1:0]            col_idx_t;
  typedef logic [$clog2(`GAT_NNZ_DEPTH)-1:0]         nnz_addr_t;
  typedef logic [$clog2(`GAT_NODE_INFO_DEPTH)-1:0]   row_addr_t;
  typedef logic [$clog2(`GAT_W_DEPTH)-1:0]           w_addr_t;
  typedef logic [$clog2(`GAT_A_DEPTH)-1:0]           a_addr_t;
  // Counts from 0 up to and including the maximum
  typedef logic [$clog2(`GAT_H_COLS + 1)-1:0]        row_len_t;
  typedef logic [$clog2(`GAT_NUM_NODES + 1)-1:0]     num_nodes_t;

  // One lane per column of W
  typedef data_t [`GAT_W_COLS-1:0] wh_vec_t;

  typedef struct packed {
    row_len_t   row_len;
    num_nodes_t num_nodes;
    logic       flag;
  } node_info_t;

  typedef struct packed {
    wh_vec_t    wh;
    data_t      coef_src;
    data_t      coef_dst;
    num_nodes_t num_nodes;
    logic       flag;
  } wh_record_t;

  //////////////////////////////////////////////////////////////////////
  // Host load strobes
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic      ena;
    nnz_addr_t addr;
    col_idx_t  din;
    logic      load_done;
  } col_idx_load_t;

  typedef struct packed {
    logic      ena;
    nnz_addr_t addr;
    data_t     din;
    logic      load_done;
  } value_load_t;

  typedef struct packed {
    logic       ena;
    row_addr_t  addr;
    node_info_t din;
    logic       load_done;
  } node_info_load_t;

  typedef struct packed {
    logic    ena;
    w_addr_t addr;
    data_t   din;
    logic    load_done;
  } weight_load_t;

  typedef struct packed {
    logic    ena;
    a_addr_t addr;
    data_t   din;
    logic    load_done;
  } a_load_t;

  typedef enum logic [2:0] {
    IDLE,
    INFO_REQ,
    INFO_WAIT,
    NNZ_ISSUE,
    DRAIN,
    FINISH
  } spmm_state_t;

endpackage

`default_nettype wire

// File: sim/gat_sva.sv
`default_nettype none

module gat_sva (
  input logic                clk,
  input logic                reset,
  input logic                start,
  input logic                node_info_rd_en,
  input logic                nnz_rd_en,
  input logic                mac_valid,
  input logic                row_done,
  input logic                wh_wr_en,
  input logic                wh_rd_en,
  input gat_pkg::wh_record_t wh_rd_data,
  input logic                compute_done
);

  // Every strobe is quiet the cycle after reset
  quiet_after_reset: assert property (@(posedge clk)
    reset |=> !compute_done && !row_done && !mac_valid &&
              !node_info_rd_en && !nnz_rd_en && !wh_wr_en)
    else $error("strobe high right after reset");

  // No memory is read before all loads are done
  no_early_start: assert property (@(posedge clk) disable iff (reset)
    !start |-> !node_info_rd_en && !nnz_rd_en)
    else $error("RAM read while a load_done is low");

  done_sticky: assert property (@(posedge clk) disable iff (reset)
    compute_done |=> compute_done)
    else $error("compute_done fell without reset");

  // Last record is already in the WH RAM when compute_done rises
  quiet_after_done: assert property (@(posedge clk) disable iff (reset)
    compute_done |-> !wh_wr_en && !row_done)
    else $error("row or record still in flight with compute_done high");

  row_done_pulse: assert property (@(posedge clk) disable iff (reset)
    row_done |=> !row_done)
    else $error("row_done longer than one cycle");

  read_data_known: assert property (@(posedge clk) disable iff (reset)
    wh_rd_en |=> !$isunknown(wh_rd_data))
    else $error("unknown bits on wh_rd_data after a read");

endmodule

bind gat_top gat_sva u_sva (
  .clk             (clk),
  .reset           (reset),
  .start           (start),
  .node_info_rd_en (node_info_rd_en),
  .nnz_rd_en       (nnz_rd_en),
  .mac_valid       (mac_valid),
  .row_done        (row_done),
  .wh_wr_en        (wh_wr_en),
  .wh_rd_en        (wh_rd_en),
  .wh_rd_data      (wh_rd_data),
  .compute_done    (compute_done)
);

`default_nettype wire

// File: sim/gat_tb.sv
`default_nettype none

`include "gat_params.svh"

module gat_tb;
  import gat_pkg::*;

  localparam int HOLD_CYCLES    = 20;
  localparam int LOAD_CYCLES    = `GAT_NNZ_DEPTH + HOLD_CYCLES + 4;
  localparam int COMPUTE_CYCLES = `GAT_H_ROWS * 8;
  localparam int READ_CYCLES    = `GAT_H_ROWS * 3;
  localparam int TIMEOUT_CYCLES = 2 * (3 + LOAD_CYCLES + COMPUTE_CYCLES + READ_CYCLES) + 200;

  logic            clk;
  logic            reset;
  col_idx_load_t   col_idx_load;
  value_load_t     value_load;
  node_info_load_t node_info_load;
  weight_load_t    weight_load;
  a_load_t         a_load;
  logic            wh_rd_en;
  row_addr_t       wh_rd_addr;
  wh_record_t      wh_rd_data;
  logic            compute_done;

  logic [31:0] rand_state = 32'hdc63;
  int          cycle_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          nnz_total;

  // Reference copy of everything loaded into the DUT
  col_idx_t    nnz_col [`GAT_NNZ_DEPTH];
  data_t       nnz_val [`GAT_NNZ_DEPTH];
  node_info_t  row_info [`GAT_H_ROWS];
  data_t       w_mem [`GAT_W_DEPTH];
  data_t       a_mem [`GAT_A_DEPTH];
  wh_record_t  expected [`GAT_H_ROWS];

  gat_top u_dut (
    .clk            (clk),
    .reset          (reset),
    .col_idx_load   (col_idx_load),
    .value_load     (value_load),
    .node_info_load (node_info_load),
    .weight_load    (weight_load),
    .a_load         (a_load),
    .wh_rd_en       (wh_rd_en),
    .wh_rd_addr     (wh_rd_addr),
    .wh_rd_data     (wh_rd_data),
    .compute_done   (compute_done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic int unsigned next_random();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return {16'h0, rand_state[31:16]};
  endfunction

  // Start latch, then every row, then row_done, record write and compute_done
  function automatic int expected_latency();
    int cycles;
    cycles = 4;
    for (int r = 0; r < `GAT_H_ROWS; r++) begin
      if (row_info[r].row_len == '0) begin
        cycles += 4;
      end else begin
        cycles += 3 + int'(row_info[r].row_len);
      end
    end
    return cycles;
  endfunction

  task automatic report_test(input string name, input bit ok);
    tests_run++;
    if (ok) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed", name);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset          <= 1'b1;
    col_idx_load   <= '0;
    value_load     <= '0;
    node_info_load <= '0;
    weight_load    <= '0;
    a_load         <= '0;
    wh_rd_en       <= 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Random H, W and a with the expected records
  //////////////////////////////////////////////////////////////////////

  task automatic generate_data();
    int                     len;
    logic [`GAT_H_COLS-1:0] mask;
    nnz_total = 0;
    for (int r = 0; r < `GAT_H_ROWS; r++) begin
      len = int'(next_random() % 5);
      if (len > `GAT_NNZ_DEPTH - nnz_total) begin
        len = `GAT_NNZ_DEPTH - nnz_total;
      end
      // Drop random columns until the row length is met
      mask = '1;
      while ($countones(mask) > len) begin
        mask[next_random() % `GAT_H_COLS] = 1'b0;
      end
      row_info[r].row_len   = row_len_t'(len);
      row_info[r].num_nodes = num_nodes_t'(next_random() % (`GAT_NUM_NODES + 1));
      row_info[r].flag      = (next_random() % 2) == 1;
      for (int c = 0; c < `GAT_H_COLS; c++) begin
        if (mask[c]) begin
          nnz_col[nnz_total] = col_idx_t'(c);
          nnz_val[nnz_total] = data_t'(next_random() % 8);
          nnz_total++;
        end
      end
    end
    for (int i = 0; i < `GAT_W_DEPTH; i++) begin
      w_mem[i] = data_t'(next_random() % 8);
    end
    for (int i = 0; i < `GAT_A_DEPTH; i++) begin
      a_mem[i] = data_t'(next_random() % 8);
    end
  endtask

  task automatic build_expected();
    int p;
    int src;
    int dst;
    int acc [`GAT_W_COLS];
    p = 0;
    for (int r = 0; r < `GAT_H_ROWS; r++) begin
      src = 0;
      dst = 0;
      for (int j = 0; j < `GAT_W_COLS; j++) begin
        acc[j] = 0;
      end
      for (int k = 0; k < int'(row_info[r].row_len); k++) begin
        for (int j = 0; j < `GAT_W_COLS; j++) begin
          acc[j] = acc[j] + nnz_val[p] * w_mem[nnz_col[p] * `GAT_W_COLS + j];
        end
        p++;
      end
      // Lanes wrap first, the coefficients use the wrapped lanes
      for (int j = 0; j < `GAT_W_COLS; j++) begin
        expected[r].wh[j] = data_t'(acc[j]);
        src = src + a_mem[j] * expected[r].wh[j];
        dst = dst + a_mem[`GAT_W_COLS + j] * expected[r].wh[j];
      end
      expected[r].coef_src  = data_t'(src);
      expected[r].coef_dst  = data_t'(dst);
      expected[r].num_nodes = row_info[r].num_nodes;
      expected[r].flag      = row_info[r].flag;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Host side of the DUT
  //////////////////////////////////////////////////////////////////////

  // All five memories share one 32-cycle load window
  task automatic load_memories();
    for (int i = 0; i < `GAT_NNZ_DEPTH; i++) begin
      @(posedge clk);
      col_idx_load.ena    <= (i < nnz_total);
      col_idx_load.addr   <= nnz_addr_t'(i);
      col_idx_load.din    <= nnz_col[i];
      value_load.ena      <= (i < nnz_total);
      value_load.addr     <= nnz_addr_t'(i);
      value_load.din      <= nnz_val[i];
      node_info_load.ena  <= (i < `GAT_H_ROWS);
      node_info_load.addr <= row_addr_t'(i % `GAT_H_ROWS);
      node_info_load.din  <= row_info[i % `GAT_H_ROWS];
      weight_load.ena     <= (i < `GAT_W_DEPTH);
      weight_load.addr    <= w_addr_t'(i % `GAT_W_DEPTH);
      weight_load.din     <= w_mem[i % `GAT_W_DEPTH];
      a_load.ena          <= (i < `GAT_A_DEPTH);
      a_load.addr         <= a_addr_t'(i % `GAT_A_DEPTH);
      a_load.din          <= a_mem[i % `GAT_A_DEPTH];
    end
  endtask

  task automatic hold_one_done(input int run);
    int held;
    int waited;
    bit ok;
    held = int'(next_random() % 5);
    ok = 1'b1;
    @(posedge clk);
    col_idx_load.ena         <= 1'b0;
    value_load.ena           <= 1'b0;
    node_info_load.ena       <= 1'b0;
    weight_load.ena          <= 1'b0;
    a_load.ena               <= 1'b0;
    col_idx_load.load_done   <= (held != 0);
    value_load.load_done     <= (held != 1);
    node_info_load.load_done <= (held != 2);
    weight_load.load_done    <= (held != 3);
    a_load.load_done         <= (held != 4);
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      @(negedge clk);
      assert (compute_done == 1'b0) else begin
        $display("Error at time %0t: compute_done high with load_done %0d low", $time, held);
        ok = 1'b0;
      end
    end
    @(posedge clk);
    col_idx_load.load_done   <= 1'b1;
    value_load.load_done     <= 1'b1;
    node_info_load.load_done <= 1'b1;
    weight_load.load_done    <= 1'b1;
    a_load.load_done         <= 1'b1;
    // Any work done during the hold shortens this count
    waited = 0;
    while (compute_done !== 1'b1) begin
      @(negedge clk);
      waited++;
    end
    assert (waited == expected_latency()) else begin
      $display("Error at time %0t: compute_done after %0d cycles, expected %0d",
               $time, waited, expected_latency());
      ok = 1'b0;
    end
    report_test($sformatf("run %0d hold", run), ok);
  endtask

  task automatic read_record(input int r, output wh_record_t rec);
    @(posedge clk);
    wh_rd_en   <= 1'b1;
    wh_rd_addr <= row_addr_t'(r);
    @(posedge clk);
    wh_rd_en <= 1'b0;
    @(negedge clk);
    rec = wh_rd_data;
  endtask

  task automatic check_records(input int run);
    wh_record_t rec;
    bit         ok;
    for (int r = 0; r < `GAT_H_ROWS; r++) begin
      read_record(r, rec);
      ok = 1'b1;
      assert (rec.wh == expected[r].wh) else begin
        $display("Error at time %0t: row %0d wh %h, expected %h",
                 $time, r, rec.wh, expected[r].wh);
        ok = 1'b0;
      end
      assert (rec.coef_src == expected[r].coef_src && rec.coef_dst == expected[r].coef_dst)
      else begin
        $display("Error at time %0t: row %0d coefs %h %h, expected %h %h", $time, r,
                 rec.coef_src, rec.coef_dst, expected[r].coef_src, expected[r].coef_dst);
        ok = 1'b0;
      end
      assert (rec.num_nodes == expected[r].num_nodes && rec.flag == expected[r].flag)
      else begin
        $display("Error at time %0t: row %0d num_nodes %0d flag %b, expected %0d %b", $time,
                 r, rec.num_nodes, rec.flag, expected[r].num_nodes, expected[r].flag);
        ok = 1'b0;
      end
      if (row_info[r].row_len == '0) begin
        assert (rec.wh == '0 && rec.coef_src == '0 && rec.coef_dst == '0) else begin
          $display("Error at time %0t: empty row %0d reads back nonzero", $time, r);
          ok = 1'b0;
        end
      end
      report_test($sformatf("run %0d row %0d", run, r), ok);
    end
  endtask

  initial begin
    reset          = 1'b1;
    col_idx_load   = '0;
    value_load     = '0;
    node_info_load = '0;
    weight_load    = '0;
    a_load         = '0;
    wh_rd_en       = 1'b0;
    wh_rd_addr     = '0;
    // Second run proves that reset clears all compute state
    for (int run = 1; run <= 2; run++) begin
      apply_reset();
      generate_data();
      build_expected();
      load_memories();
      hold_one_done(run);
      check_records(run);
    end
    $display("Tests run: %0d, passed: %0d, failed: %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: spmm/spmm_sequencer.sv
`default_nettype none

`include "gat_params.svh"

module spmm_sequencer (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  output logic                node_info_rd_en,
  output gat_pkg::row_addr_t  node_info_rd_addr,
  input  gat_pkg::node_info_t node_info,
  output logic                nnz_rd_en,
  output gat_pkg::nnz_addr_t  nnz_rd_addr,
  output logic                mac_valid,
  output logic                mac_clear,
  output logic                row_done,
  output gat_pkg::node_info_t row_info,
  output gat_pkg::row_addr_t  row_addr,
  output logic                compute_done
);
  import gat_pkg::*;

  spmm_state_t state;
  row_addr_t   row_ptr;
  nnz_addr_t   nnz_ptr;
  node_info_t  cur_info;
  row_len_t    issue_cnt;
  logic        last_issue;
  logic        last_row;

  assign node_info_rd_en   = (state == INFO_REQ);
  assign node_info_rd_addr = row_ptr;
  // Empty rows still take one issue slot, but read nothing
  assign nnz_rd_en         = (state == NNZ_ISSUE) && (cur_info.row_len != '0);
  assign nnz_rd_addr       = nnz_ptr;
  assign row_info          = cur_info;

  assign last_issue = (cur_info.row_len <= row_len_t'(issue_cnt + 1'b1));
  assign last_row   = (row_ptr == row_addr_t'(`GAT_H_ROWS - 1));

  //////////////////////////////////////////////////////////////////////
  // Row walk
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      row_ptr   <= '0;
      nnz_ptr   <= '0;
      cur_info  <= '0;
      issue_cnt <= '0;
      row_addr  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= INFO_REQ;
          end
        end
        INFO_REQ: begin
          state <= INFO_WAIT;
        end
        INFO_WAIT: begin
          // RAM output is valid here
          cur_info  <= node_info;
          issue_cnt <= '0;
          state     <= NNZ_ISSUE;
        end
        NNZ_ISSUE: begin
          issue_cnt <= issue_cnt + 1'b1;
          // Nonzeros are packed, so the pointer runs on across rows
          if (nnz_rd_en) begin
            nnz_ptr <= nnz_ptr + 1'b1;
          end
          if (last_issue) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          row_addr <= row_ptr;
          row_ptr  <= row_ptr + 1'b1;
          state    <= last_row ? FINISH : INFO_REQ;
        end
        FINISH: begin
          state <= FINISH;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Strobes toward the MAC array and the attention unit
  always_ff @(posedge clk) begin
    if (reset) begin
      mac_valid    <= 1'b0;
      mac_clear    <= 1'b0;
      row_done     <= 1'b0;
      compute_done <= 1'b0;
    end else begin
      mac_valid <= nnz_rd_en;
      mac_clear <= (state == NNZ_ISSUE) && (issue_cnt == '0);
      row_done  <= (state == DRAIN);
      // Last record is written the cycle after the final row_done
      if ((state == FINISH) && !row_done) begin
        compute_done <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: spmm/wh_mac_array.sv
`default_nettype none

`include "gat_params.svh"

module wh_mac_array (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                mac_valid,
  input  logic                                mac_clear,
  input  gat_pkg::col_idx_t                   col_idx,
  input  gat_pkg::data_t                      value,
  input  gat_pkg::data_t [`GAT_W_DEPTH-1:0]   weights,
  output gat_pkg::wh_vec_t                    wh
);
  import gat_pkg::*;

  wh_vec_t prod;

  // Lane j takes W[col_idx][j], products wrap at 8 bits
  always_comb begin
    for (int j = 0; j < `GAT_W_COLS; j++) begin
      prod[j] = value * weights[w_addr_t'(col_idx * `GAT_W_COLS + j)];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wh <= '0;
    end else if (mac_clear) begin
      // Clear alone marks an empty row
      wh <= mac_valid ? prod : '0;
    end else if (mac_valid) begin
      for (int j = 0; j < `GAT_W_COLS; j++) begin
        wh[j] <= wh[j] + prod[j];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/gat_pkg.sv
verilog/dual_port_bram.sv
verilog/vector_regfile.sv
spmm/spmm_sequencer.sv
spmm/wh_mac_array.sv
attention/attention_coef.sv
verilog/gat_top.sv
sim/gat_sva.sv
sim/gat_tb.sv

// File: verilog/dual_port_bram.sv
`default_nettype none

module dual_port_bram #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     ena,
  input  logic [$clog2(DEPTH)-1:0] addra,
  input  logic [WIDTH-1:0]         dina,
  input  logic                     enb,
  input  logic [$clog2(DEPTH)-1:0] addrb,
  output logic [WIDTH-1:0]         doutb
);

  logic [WIDTH-1:0] mem [DEPTH];

  // Port A, write only
  always_ff @(posedge clk) begin
    if (ena) begin
      mem[addra] <= dina;
    end
  end

  // Port B, read data appears the cycle after enb
  always_ff @(posedge clk) begin
    if (enb) begin
      doutb <= mem[addrb];
    end
  end

endmodule

`default_nettype wire

// File: verilog/gat_top.sv
`default_nettype none

`include "gat_params.svh"

module gat_top (
  input  logic                     clk,
  input  logic                     reset,
  input  gat_pkg::col_idx_load_t   col_idx_load,
  input  gat_pkg::value_load_t     value_load,
  input  gat_pkg::node_info_load_t node_info_load,
  input  gat_pkg::weight_load_t    weight_load,
  input  gat_pkg::a_load_t         a_load,
  input  logic                     wh_rd_en,
  input  gat_pkg::row_addr_t       wh_rd_addr,
  output gat_pkg::wh_record_t      wh_rd_data,
  output logic                     compute_done
);
  import gat_pkg::*;

  logic                      start;
  logic                      node_info_rd_en;
  row_addr_t                 node_info_rd_addr;
  node_info_t                node_info;
  logic                      nnz_rd_en;
  nnz_addr_t                 nnz_rd_addr;
  col_idx_t                  col_idx;
  data_t                     value;
  logic                      mac_valid;
  logic                      mac_clear;
  logic                      row_done;
  node_info_t                row_info;
  row_addr_t                 row_addr;
  wh_vec_t                   wh;
  data_t [`GAT_W_DEPTH-1:0]  weights;
  data_t [`GAT_A_DEPTH-1:0]  a_vec;
  logic                      wh_wr_en;
  row_addr_t                 wh_wr_addr;
  wh_record_t                wh_wr_data;

  // Compute waits for every memory
  assign start = col_idx_load.load_done & value_load.load_done &
                 node_info_load.load_done & weight_load.load_done & a_load.load_done;

  //////////////////////////////////////////////////////////////////////
  // Storage for H, W and a
  //////////////////////////////////////////////////////////////////////

  dual_port_bram #(.WIDTH($bits(col_idx_t)), .DEPTH(`GAT_NNZ_DEPTH)) u_col_idx_ram (
    .clk   (clk),
    .ena   (col_idx_load.ena),
    .addra (col_idx_load.addr),
    .dina  (col_idx_load.din),
    .enb   (nnz_rd_en),
    .addrb (nnz_rd_addr),
    .doutb (col_idx)
  );

  dual_port_bram #(.WIDTH($bits(data_t)), .DEPTH(`GAT_NNZ_DEPTH)) u_value_ram (
    .clk   (clk),
    .ena   (value_load.ena),
    .addra (value_load.addr),
    .dina  (value_load.din),
    .enb   (nnz_rd_en),
    .addrb (nnz_rd_addr),
    .doutb (value)
  );

  dual_port_bram #(.WIDTH($bits(node_info_t)), .DEPTH(`GAT_NODE_INFO_DEPTH)) u_node_info_ram (
    .clk   (clk),
    .ena   (node_info_load.ena),
    .addra (node_info_load.addr),
    .dina  (node_info_load.din),
    .enb   (node_info_rd_en),
    .addrb (node_info_rd_addr),
    .doutb (node_info)
  );

  vector_regfile #(.DEPTH(`GAT_W_DEPTH)) u_weight_rf (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (weight_load.ena),
    .wr_addr (weight_load.addr),
    .wr_data (weight_load.din),
    .entries (weights)
  );

  vector_regfile #(.DEPTH(`GAT_A_DEPTH)) u_a_rf (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (a_load.ena),
    .wr_addr (a_load.addr),
    .wr_data (a_load.din),
    .entries (a_vec)
  );

  //////////////////////////////////////////////////////////////////////
  // Compute path
  //////////////////////////////////////////////////////////////////////

  spmm_sequencer u_seq (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .node_info_rd_en   (node_info_rd_en),
    .node_info_rd_addr (node_info_rd_addr),
    .node_info         (node_info),
    .nnz_rd_en         (nnz_rd_en),
    .nnz_rd_addr       (nnz_rd_addr),
    .mac_valid         (mac_valid),
    .mac_clear         (mac_clear),
    .row_done          (row_done),
    .row_info          (row_info),
    .row_addr          (row_addr),
    .compute_done      (compute_done)
  );

  wh_mac_array u_mac (
    .clk       (clk),
    .reset     (reset),
    .mac_valid (mac_valid),
    .mac_clear (mac_clear),
    .col_idx   (col_idx),
    .value     (value),
    .weights   (weights),
    .wh        (wh)
  );

  attention_coef u_attn (
    .clk        (clk),
    .reset      (reset),
    .row_done   (row_done),
    .row_info   (row_info),
    .row_addr   (row_addr),
    .wh         (wh),
    .a_vec      (a_vec),
    .wh_wr_en   (wh_wr_en),
    .wh_wr_addr (wh_wr_addr),
    .wh_wr_data (wh_wr_data)
  );

  // Results, read back by the host
  dual_port_bram #(.WIDTH($bits(wh_record_t)), .DEPTH(`GAT_WH_DEPTH)) u_wh_ram (
    .clk   (clk),
    .ena   (wh_wr_en),
    .addra (wh_wr_addr),
    .dina  (wh_wr_data),
    .enb   (wh_rd_en),
    .addrb (wh_rd_addr),
    .doutb (wh_rd_data)
  );

endmodule

`default_nettype wire

// File: verilog/vector_regfile.sv
`default_nettype none

module vector_regfile #(
  parameter int DEPTH = 16
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       wr_en,
  input  logic [$clog2(DEPTH)-1:0]   wr_addr,
  input  gat_pkg::data_t             wr_data,
  output gat_pkg::data_t [DEPTH-1:0] entries
);

  // Whole vector is visible every cycle, so all MAC lanes
  // can read their weight at once
  always_ff @(posedge clk) begin
    if (reset) begin
      entries <= '0;
    end else if (wr_en) begin
      entries[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire
